//--- Makefile
TOP := complexFirTb

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module $(TOP) -f vlog.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q "tests failed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- rtl/coeffBank.sv
module coeffBank #(
	parameter int TAPS = 12
) (
	input  logic                               clock,
	input  logic                               rstN,
	input  logic                               coeffShift,
	input  firPkg::complexSample               coeffIn,
	output firPkg::complexSample [TAPS-1:0]    coeffs
);
	import firPkg::*;

	// Bank contents after one more shift.
	complexSample [TAPS-1:0] shifted;

	// A new coefficient enters at the top slot and every stored value
	// moves one slot down toward slot zero.
	// Slot zero falls off, so a load longer than TAPS keeps only the
	// last TAPS values.
	// After a load of exactly TAPS values, slot k holds h_k, the k-th
	// coefficient in load order.
	// That slot pairs with the sample accepted k acceptances earlier.
	always_comb begin
		shifted = {coeffIn, coeffs[TAPS-1:1]};
	end

	// The bank itself.
	// Slots never written since reset stay zero and add nothing to a sum.
	// A value shifted in at one edge is visible on coeffs right after it.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			coeffs <= '0;
		end else if (coeffShift) begin
			coeffs <= shifted;
		end
	end

endmodule

//--- rtl/complexFir.sv
module complexFir #(
	parameter int TAPS = 12
) (
	input  logic                 clock,
	input  logic                 rstN,
	input  logic                 loadCoefficients,
	input  logic                 coefficientsSet,
	input  logic                 loadData,
	input  logic                 stopData,
	input  firPkg::complexSample coeffIn,
	input  firPkg::complexSample sampleIn,
	output firPkg::complexResult result,
	output logic                 outValid,
	output logic                 running
);
	import firPkg::*;

	// Enables from the controller.
	logic coeffShift;
	logic historyClear;
	logic sampleAccept;

	// All coefficients, presented in parallel to the datapath.
	complexSample [TAPS-1:0] coeffs;

	// The controller is the only block that looks at the host strobes.
	// It turns them into a shift enable for the bank and a clear and an
	// accept enable for the datapath.
	firControl u_firControl (
		.clock            (clock),
		.rstN             (rstN),
		.loadCoefficients (loadCoefficients),
		.coefficientsSet  (coefficientsSet),
		.loadData         (loadData),
		.stopData         (stopData),
		.coeffShift       (coeffShift),
		.historyClear     (historyClear),
		.sampleAccept     (sampleAccept),
		.running          (running)
	);

	// Coefficient store.
	// Reloading replaces values one per shift, oldest first out.
	coeffBank #(
		.TAPS (TAPS)
	) u_coeffBank (
		.clock      (clock),
		.rstN       (rstN),
		.coeffShift (coeffShift),
		.coeffIn    (coeffIn),
		.coeffs     (coeffs)
	);

	// Two-stage datapath.
	// The result of a sample accepted at one edge appears together with
	// outValid two edges later, with no gaps needed between samples.
	firDatapath #(
		.TAPS (TAPS)
	) u_firDatapath (
		.clock        (clock),
		.rstN         (rstN),
		.historyClear (historyClear),
		.sampleAccept (sampleAccept),
		.sampleIn     (sampleIn),
		.coeffs       (coeffs),
		.result       (result),
		.outValid     (outValid)
	);

endmodule

//--- rtl/firControl.sv
module firControl (
	input  logic clock,
	input  logic rstN,
	input  logic loadCoefficients,
	input  logic coefficientsSet,
	input  logic loadData,
	input  logic stopData,
	output logic coeffShift,
	output logic historyClear,
	output logic sampleAccept,
	output logic running
);
	import firPkg::*;

	// Current and next controller state.
	firState state;
	firState nextState;

	// State register.
	// The controller comes out of reset waiting in idle.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= idle;
		end else begin
			state <= nextState;
		end
	end

	// Next state and the enables for the bank and the datapath.
	// The enables depend on the current state and on the host strobes
	// of this same cycle, so the bank and the history react at the
	// edge that closes the cycle in which the host raised its strobe.
	always_comb begin
		nextState    = state;
		coeffShift   = 1'b0;
		historyClear = 1'b0;
		sampleAccept = 1'b0;

		case (state)
			loadCoeffs: begin
				// The cycle that carries coefficientsSet holds no coefficient.
				// Every other cycle in this state shifts coeffIn into the bank.
				if (coefficientsSet) begin
					nextState = run;
				end else begin
					coeffShift = 1'b1;
				end
			end

			run: begin
				// A sample presented together with stopData still goes in.
				sampleAccept = loadData;
				if (stopData) begin
					nextState = stop;
				end
			end

			stop: begin
				// One cycle here lets the host see running drop before a reload.
				nextState = idle;
			end

			default: begin
				// Idle, and also the landing point for any unknown encoding.
				// Starting a load wipes the sample history so that the next
				// run begins from an all-zero history.
				nextState = idle;
				if (loadCoefficients) begin
					nextState    = loadCoeffs;
					historyClear = 1'b1;
				end
			end
		endcase
	end

	// Running is a pure state decode.
	// It rises on the edge after coefficientsSet and falls on the edge
	// after stopData.
	assign running = (state == run);

endmodule

//--- rtl/firDatapath.sv
module firDatapath #(
	parameter int TAPS = 12
) (
	input  logic                               clock,
	input  logic                               rstN,
	input  logic                               historyClear,
	input  logic                               sampleAccept,
	input  firPkg::complexSample               sampleIn,
	input  firPkg::complexSample [TAPS-1:0]    coeffs,
	output firPkg::complexResult               result,
	output logic                               outValid
);
	import firPkg::*;

	// Sample history line.
	// Element zero is the newest accepted sample.
	complexSample [TAPS-1:0] history;
	complexSample [TAPS-1:0] historyNext;

	// First pipeline stage, the four products of every tap.
	crossProducts [TAPS-1:0] productsNext;
	crossProducts [TAPS-1:0] products;

	// Second pipeline stage inputs, the four real sums over all taps.
	logic signed [resultWidth-1:0] sumReRe;
	logic signed [resultWidth-1:0] sumImIm;
	logic signed [resultWidth-1:0] sumReIm;
	logic signed [resultWidth-1:0] sumImRe;
	complexResult                  resultNext;

	// Bit zero marks a valid product stage and bit one a valid result.
	logic [1:0] validPipe;

	// Full precision signed multiply of two sample parts.
	// Both operands are widened first so the product cannot wrap.
	function automatic logic signed [productWidth-1:0] mulPart(
		input logic signed [sampleWidth-1:0] a,
		input logic signed [sampleWidth-1:0] b
	);
		return productWidth'(a) * productWidth'(b);
	endfunction

	// History as it will be after this edge.
	// A clear only happens while loading coefficients and an accept only
	// while running, so the two never meet.
	// On an accept the new sample lands in element zero and the oldest
	// sample drops out of the top.
	always_comb begin
		historyNext = history;
		if (historyClear) begin
			historyNext = '0;
		end else if (sampleAccept) begin
			historyNext = {history[TAPS-2:0], sampleIn};
		end
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			history <= '0;
		end else begin
			history <= historyNext;
		end
	end

	// Products are formed from the updated history.
	// That way the sample accepted at this edge already takes part in
	// its own result without waiting a cycle in the history line.
	always_comb begin
		for (int k = 0; k < TAPS; k++) begin
			productsNext[k].reRe = mulPart(historyNext[k].re, coeffs[k].re);
			productsNext[k].imIm = mulPart(historyNext[k].im, coeffs[k].im);
			productsNext[k].reIm = mulPart(historyNext[k].re, coeffs[k].im);
			productsNext[k].imRe = mulPart(historyNext[k].im, coeffs[k].re);
		end
	end

	// Product stage register, loaded only by an accepted sample.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			products <= '0;
		end else if (sampleAccept) begin
			products <= productsNext;
		end
	end

	// Adder trees for the four real sums.
	// Each product is sign extended to the result width before it is added.
	always_comb begin
		sumReRe = '0;
		sumImIm = '0;
		sumReIm = '0;
		sumImRe = '0;
		for (int k = 0; k < TAPS; k++) begin
			sumReRe = sumReRe + resultWidth'(products[k].reRe);
			sumImIm = sumImIm + resultWidth'(products[k].imIm);
			sumReIm = sumReIm + resultWidth'(products[k].reIm);
			sumImRe = sumImRe + resultWidth'(products[k].imRe);
		end

		// Complex multiply accumulate, (a + jb)(c + jd) summed over taps.
		resultNext.re = sumReRe - sumImIm;
		resultNext.im = sumReIm + sumImRe;
	end

	// Result register and the valid shift register.
	// The valid bits move every cycle, so back-to-back samples give
	// back-to-back results, each two cycles after its accept.
	// The result holds its last value between strobes.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			result    <= '0;
			validPipe <= '0;
		end else begin
			validPipe <= {validPipe[0], sampleAccept};
			if (validPipe[0]) begin
				result <= resultNext;
			end
		end
	end

	assign outValid = validPipe[1];

endmodule

//--- rtl/firPkg.sv
package firPkg;

	// Width of one real or imaginary part of a sample or a coefficient.
	localparam int sampleWidth = 8;

	// Width of one real or imaginary part of a filter result.
	// Two sample widths hold a single product, and the extra sample width
	// leaves room for the growth of a sum over up to twelve taps.
	localparam int resultWidth = 3 * sampleWidth;

	// A product of two signed parts needs exactly twice the sample width.
	localparam int productWidth = 2 * sampleWidth;

	// One complex input sample or one complex coefficient.
	// The real part sits in the upper half of the packed word.
	typedef struct packed {
		logic signed [sampleWidth-1:0] re;
		logic signed [sampleWidth-1:0] im;
	} complexSample;

	// One complex filter result at full precision.
	typedef struct packed {
		logic signed [resultWidth-1:0] re;
		logic signed [resultWidth-1:0] im;
	} complexResult;

	// The four real products of one tap.
	// A complex multiply is built from these after summation.
	typedef struct packed {
		logic signed [productWidth-1:0] reRe;
		logic signed [productWidth-1:0] imIm;
		logic signed [productWidth-1:0] reIm;
		logic signed [productWidth-1:0] imRe;
	} crossProducts;

	// Controller states.
	// All four encodings of the two-bit register are in use.
	// idle waits for a coefficient load request.
	// loadCoeffs shifts coefficients into the bank.
	// run accepts samples into the datapath.
	// stop is a single cycle on the way back to idle.
	typedef enum logic [1:0] {
		idle       = 2'd0,
		loadCoeffs = 2'd1,
		run        = 2'd2,
		stop       = 2'd3
	} firState;

endpackage

//--- tests/complexFirTb.sv
module complexFirTb;
	import firPkg::*;

	localparam int TAPS = 12;

	// The tests take about 350 cycles, so this leaves a wide margin.
	localparam int timeoutCycles = 1500;

	typedef complexSample sampleQueue[$];

	logic         clock;
	logic         rstN;
	logic         loadCoefficients;
	logic         coefficientsSet;
	logic         loadData;
	logic         stopData;
	complexSample coeffIn;
	complexSample sampleIn;
	complexResult result;
	logic         outValid;
	logic         running;

	// Cycle number, read by the checker to time each expected result.
	int   cycleCount = 0;
	logic timedOut = 1'b0;
	logic runningExpected;

	// Whether a sample driven now will be accepted, seen from the drive edge.
	bit acceptModel = 1'b0;

	// Model of the last TAPS loaded coefficients, index k holding h_k.
	complexSample coeffLog[$];
	// Model of the accepted samples, newest first.
	complexSample historyQ[$];

	complexFir #(
		.TAPS (TAPS)
	) u_complexFir (
		.clock            (clock),
		.rstN             (rstN),
		.loadCoefficients (loadCoefficients),
		.coefficientsSet  (coefficientsSet),
		.loadData         (loadData),
		.stopData         (stopData),
		.coeffIn          (coeffIn),
		.sampleIn         (sampleIn),
		.result           (result),
		.outValid         (outValid),
		.running          (running)
	);

	firChecker u_firChecker (
		.clock           (clock),
		.rstN            (rstN),
		.cycleCount      (cycleCount),
		.runningExpected (runningExpected),
		.result          (result),
		.outValid        (outValid),
		.running         (running)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Expected filter output for one history, summed at full precision.
	// Missing history entries count as zero.
	function automatic complexResult firReference(input complexSample hist[$],
			input complexSample taps[$]);
		longint reRe;
		longint imIm;
		longint reIm;
		longint imRe;
		complexSample x;
		complexResult r;
		reRe = 0;
		imIm = 0;
		reIm = 0;
		imRe = 0;
		for (int k = 0; k < TAPS; k++) begin
			x = (k < hist.size()) ? hist[k] : '0;
			reRe += longint'(x.re) * longint'(taps[k].re);
			imIm += longint'(x.im) * longint'(taps[k].im);
			reIm += longint'(x.re) * longint'(taps[k].im);
			imRe += longint'(x.im) * longint'(taps[k].re);
		end
		r.re = resultWidth'(reRe - imIm);
		r.im = resultWidth'(reIm + imRe);
		return r;
	endfunction

	// Random sample, or one with every part at -128 or 127.
	function automatic complexSample randomSample(input bit extreme);
		logic [31:0] bits;
		complexSample s;
		bits = $urandom();
		s.re = bits[7:0];
		s.im = bits[15:8];
		if (extreme) begin
			s.re = bits[0] ? 8'sh80 : 8'sh7f;
			s.im = bits[1] ? 8'sh80 : 8'sh7f;
		end
		return s;
	endfunction

	function automatic sampleQueue randomSet(input int count, input bit extreme);
		sampleQueue values;
		for (int i = 0; i < count; i++) begin
			values.push_back(randomSample(extreme));
		end
		return values;
	endfunction

	// Starts a load from idle, shifts in every value and enters run.
	// loadData is left as it was until the last edge, so a strobe held
	// through the load must not be taken as a sample.
	task automatic loadCoeffSet(input sampleQueue values);
		@(posedge clock);
		loadCoefficients <= 1'b1;
		historyQ.delete();
		@(posedge clock);
		loadCoefficients <= 1'b0;
		foreach (values[i]) begin
			coeffIn <= values[i];
			coeffLog.push_back(values[i]);
			void'(coeffLog.pop_front());
			@(posedge clock);
		end
		coefficientsSet <= 1'b1;
		loadData        <= 1'b0;
		@(posedge clock);
		coefficientsSet <= 1'b0;
		runningExpected <= 1'b1;
		acceptModel = 1'b1;
	endtask

	// Updates the sample history and queues the expected result.
	// It is due three counts after the drive edge, which is right after
	// the second edge that follows the drive edge.
	task automatic modelAccept(input complexSample s);
		historyQ.push_front(s);
		if (historyQ.size() > TAPS) begin
			void'(historyQ.pop_back());
		end
		u_firChecker.addExpected(firReference(historyQ, coeffLog), cycleCount + 3);
	endtask

	task automatic sendSample(input complexSample s);
		@(posedge clock);
		loadData <= 1'b1;
		sampleIn <= s;
		if (acceptModel) begin
			modelAccept(s);
		end
	endtask

	task automatic pauseData(input int cycles);
		repeat (cycles) begin
			@(posedge clock);
			loadData <= 1'b0;
		end
	endtask

	// Raises stopData for one cycle, optionally with a last sample.
	task automatic stopRun(input bit withSample);
		complexSample s;
		s = randomSample(1'b0);
		@(posedge clock);
		stopData <= 1'b1;
		loadData <= withSample;
		sampleIn <= s;
		if (withSample) begin
			modelAccept(s);
		end
		acceptModel = 1'b0;
		@(posedge clock);
		stopData        <= 1'b0;
		// A last sample stays presented through the stop cycle and must be ignored there.
		loadData        <= withSample;
		runningExpected <= 1'b0;
	endtask

	task automatic waitResults();
		while (u_firChecker.pendingCount() != 0) begin
			@(posedge clock);
		end
	endtask

	task automatic reportAndFinish();
		int leftover;
		leftover = u_firChecker.pendingCount();
		if (leftover != 0) begin
			$display("%0d expected results had not appeared when the run ended.", leftover);
		end
		$display("Closing report: %0d value mismatches, %0d protocol errors, %0d timeouts",
			u_firChecker.mismatchCount, u_firChecker.protocolCount + leftover, timedOut);
		if (u_firChecker.mismatchCount == 0 && u_firChecker.protocolCount == 0
				&& leftover == 0 && !timedOut) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	endtask

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("Timeout after %0d cycles, the tests did not finish.", cycleCount);
			timedOut = 1'b1;
			reportAndFinish();
		end
	end

	initial begin
		complexSample impulse;
		complexSample mostNegative;
		void'($urandom(32'h24cf));
		rstN             <= 1'b0;
		loadCoefficients <= 1'b0;
		coefficientsSet  <= 1'b0;
		loadData         <= 1'b0;
		stopData         <= 1'b0;
		coeffIn          <= '0;
		sampleIn         <= '0;
		runningExpected  <= 1'b0;
		for (int i = 0; i < TAPS; i++) begin
			coeffLog.push_back('0);
		end
		repeat (8) @(posedge clock);
		rstN <= 1'b1;

		// Samples in idle are ignored, and loadData stays high into the load.
		sendSample(randomSample(1'b0));
		sendSample(randomSample(1'b0));

		// Impulse response walks through h0 to h11 and then reads zero.
		loadCoeffSet(randomSet(TAPS, 1'b0));
		impulse.re = 8'sd1;
		impulse.im = 8'sd0;
		sendSample(impulse);
		repeat (TAPS) begin
			sendSample('0);
		end
		stopRun(1'b0);

		// Random streaming with random gaps, ending with a sample on stop.
		loadCoeffSet(randomSet(TAPS, 1'b0));
		repeat (100) begin
			sendSample(randomSample(1'b0));
			if ($urandom_range(0, 3) == 0) begin
				pauseData($urandom_range(1, 3));
			end
		end
		stopRun(1'b1);

		// Over-long load keeps the last 12, then a reload starts from zero history.
		loadCoeffSet(randomSet(15, 1'b0));
		repeat (30) begin
			sendSample(randomSample(1'b0));
		end
		stopRun(1'b0);
		loadCoeffSet(randomSet(TAPS, 1'b0));
		repeat (20) begin
			sendSample(randomSample(1'b0));
		end
		stopRun(1'b0);

		// Extreme values with a full history.
		loadCoeffSet(randomSet(TAPS, 1'b1));
		mostNegative.re = 8'sh80;
		mostNegative.im = 8'sh80;
		repeat (TAPS) begin
			sendSample(mostNegative);
		end
		repeat (2 * TAPS) begin
			sendSample(randomSample(1'b1));
		end
		stopRun(1'b1);

		// loadData during stop and idle gives no result.
		repeat (3) begin
			sendSample(randomSample(1'b0));
		end
		pauseData(4);

		waitResults();
		reportAndFinish();
	end

endmodule

//--- tests/complexFir_asserts.sv
module complexFir_asserts (
	input logic                 clock,
	input logic                 rstN,
	input firPkg::firState      state,
	input logic                 loadCoefficients,
	input logic                 coeffShift,
	input logic                 historyClear,
	input logic                 sampleAccept,
	input logic                 outValid,
	input firPkg::complexResult result
);
	import firPkg::*;

	// The bank shifts only while loading and the history takes samples only while running.
	shiftAcceptExclusive: assert property (@(posedge clock) disable iff (!rstN)
		!(coeffShift && sampleAccept))
		else $error("coeffShift and sampleAccept were high together");

	// A clear belongs to a load request seen in idle.
	clearOnlyFromIdle: assert property (@(posedge clock) disable iff (!rstN)
		historyClear |-> (state == idle) && loadCoefficients)
		else $error("historyClear was high outside a load request in idle");

	clearEntersLoad: assert property (@(posedge clock) disable iff (!rstN)
		historyClear |=> (state == loadCoeffs))
		else $error("historyClear was not followed by the loadCoeffs state");

	// The two pipeline stages put each result exactly two edges after its accept.
	validLatency: assert property (@(posedge clock) disable iff (!rstN)
		outValid == $past(sampleAccept, 2))
		else $error("outValid did not follow sampleAccept by two cycles");

	resultKnown: assert property (@(posedge clock) disable iff (!rstN)
		outValid |-> !$isunknown(result))
		else $error("result had unknown bits while outValid was high");

endmodule

bind complexFir complexFir_asserts u_asserts (
	.clock            (clock),
	.rstN             (rstN),
	.state            (u_firControl.state),
	.loadCoefficients (loadCoefficients),
	.coeffShift       (coeffShift),
	.historyClear     (historyClear),
	.sampleAccept     (sampleAccept),
	.outValid         (outValid),
	.result           (result)
);

//--- tests/firChecker.sv
module firChecker (
	input logic                 clock,
	input logic                 rstN,
	input int                   cycleCount,
	input logic                 runningExpected,
	input firPkg::complexResult result,
	input logic                 outValid,
	input logic                 running
);
	import firPkg::*;

	// One predicted result and the cycle count at which it must show.
	typedef struct packed {
		complexResult value;
		int           dueCycle;
	} expectation;

	expectation expectQ[$];

	int mismatchCount = 0;
	int protocolCount = 0;

	task automatic addExpected(input complexResult value, input int dueCycle);
		expectation e;
		e.value    = value;
		e.dueCycle = dueCycle;
		expectQ.push_back(e);
	endtask

	function automatic int pendingCount();
		return expectQ.size();
	endfunction

	// Outputs change on the rising edge, so they are read in the middle
	// of the cycle, on the falling edge.
	always @(negedge clock) begin
		expectation e;
		if (rstN) begin
			// Anything whose cycle has passed was never presented.
			while (expectQ.size() != 0 && expectQ[0].dueCycle < cycleCount) begin
				$display("Result due at cycle %0d never appeared.", expectQ[0].dueCycle);
				protocolCount++;
				void'(expectQ.pop_front());
			end

			if (outValid) begin
				if (expectQ.size() == 0) begin
					$display("outValid was high at cycle %0d with no sample accepted.", cycleCount);
					protocolCount++;
				end else if (expectQ[0].dueCycle != cycleCount) begin
					$display("outValid was high at cycle %0d, the next result is due at %0d.",
						cycleCount, expectQ[0].dueCycle);
					protocolCount++;
				end else begin
					e = expectQ.pop_front();
					if (result.re !== e.value.re) begin
						$display("[FAIL] result.re: expected %h, actual %h", e.value.re, result.re);
						mismatchCount++;
					end
					if (result.im !== e.value.im) begin
						$display("[FAIL] result.im: expected %h, actual %h", e.value.im, result.im);
						mismatchCount++;
					end
				end
			end

			// Running must follow the run state of the controller.
			if (running !== runningExpected) begin
				$display("[FAIL] running: expected %h, actual %h", runningExpected, running);
				mismatchCount++;
			end
		end
	end

endmodule

//--- vlog.f
rtl/firPkg.sv
rtl/firControl.sv
rtl/coeffBank.sv
rtl/firDatapath.sv
rtl/complexFir.sv
tests/firChecker.sv
tests/complexFir_asserts.sv
tests/complexFirTb.sv
